// File: source/opl3_defs.svh
/*
 * OPL3 output stage parameters.
 * sample and DAC widths, the DAC scale shift, frame buffering
 * and credit depth, and the clock-crossing flop count.
 */
`ifndef OPL3_DEFS_SVH
`define OPL3_DEFS_SVH

// ========================================
// sample widths
// ========================================
`define OPL3_SAMPLE_WIDTH 16 // one operator channel, signed.
`define OPL3_DAC_WIDTH 24 // one output sample per side, signed.

// 17-bit pair sum shifted by 4 lands in 21 bits, so 24 never overflows.
`define OPL3_DAC_LEFT_SHIFT 4

// ========================================
// buffering and crossing
// ========================================
`define OPL3_FIFO_DEPTH 4 // frames held in the transmitter.
`define OPL3_CREDITS 4 // credits granted by the consumer after reset.
`define OPL3_SYNC_STAGES 2 // flops per synchronizer.

`endif

// File: source/opl3_pkg.sv
/*
 * OPL3 output stage types.
 * the channel set latched by the operator core and
 * the stereo frame handed to the DAC side.
 */
`include "opl3_defs.svh"

package opl3_pkg;

    // ========================================
    // operator core output
    // ========================================

    // four channel outputs, held for a whole sample period.
    typedef struct packed {
        logic signed [`OPL3_SAMPLE_WIDTH-1:0] a; // left pair, first.
        logic signed [`OPL3_SAMPLE_WIDTH-1:0] b; // right pair, first.
        logic signed [`OPL3_SAMPLE_WIDTH-1:0] c; // left pair, second.
        logic signed [`OPL3_SAMPLE_WIDTH-1:0] d; // right pair, second.
    } channel_set_t;

    // ========================================
    // mixed output
    // ========================================

    // one stereo sample at DAC width.
    typedef struct packed {
        logic signed [`OPL3_DAC_WIDTH-1:0] l; // a + c, scaled.
        logic signed [`OPL3_DAC_WIDTH-1:0] r; // b + d, scaled.
    } stereo_frame_t;

endpackage

// File: source/synchronizer.sv
/*
 * Single-bit synchronizer.
 * a chain of flops in the destination clock that settles a
 * slowly changing level coming from another clock domain.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module synchronizer #(
    parameter int stages = `OPL3_SYNC_STAGES
) (
    input  logic clk,
    input  logic rst,
    input  logic d,
    output logic q
);

    logic [stages-1:0] chain; // chain[0] takes the async level.

    always_ff @(posedge clk) begin
        if (rst) begin
            chain <= '0;
        end else begin
            chain <= {chain[stages-2:0], d}; // shift toward the msb.
        end
    end

    assign q = chain[stages-1]; // last flop is the settled copy.

    // one flop alone gives no time for metastability to resolve.
    a_min_stages: assert property (@(posedge clk) stages >= 2)
        else $error("synchronizer needs at least two stages.");

endmodule

// File: source/channel_adder.sv
/*
 * Channel adder with host clock handoff.
 * sums channel pairs a+c and b+d, scales them to DAC width,
 * and carries the frame into the host clock. only the valid
 * toggle crosses through a synchronizer; the sums are stable
 * for the whole sample period when the host latches them.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module channel_adder
    import opl3_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          clk_host,
    input  logic          rst_host,
    input  channel_set_t  channels,
    input  logic          channel_valid,
    output stereo_frame_t frame,
    output logic          frame_valid
);

    // sign extend one channel sample to DAC width.
    function automatic logic signed [`OPL3_DAC_WIDTH-1:0] widen(
        input logic signed [`OPL3_SAMPLE_WIDTH-1:0] s
    );
        return {{(`OPL3_DAC_WIDTH - `OPL3_SAMPLE_WIDTH){s[`OPL3_SAMPLE_WIDTH-1]}}, s};
    endfunction

    // ========================================
    // operator clock side
    // ========================================

    stereo_frame_t sum_frame; // held until the next channel_valid.
    logic          valid_tgl; // flips once per sample.

    // the channels are normally mixed in the analog domain, here digitally.
    always_ff @(posedge clk) begin
        if (channel_valid) begin
            sum_frame.l <= (widen(channels.a) + widen(channels.c)) <<< `OPL3_DAC_LEFT_SHIFT;
            sum_frame.r <= (widen(channels.b) + widen(channels.d)) <<< `OPL3_DAC_LEFT_SHIFT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_tgl <= 1'b0;
        end else if (channel_valid) begin
            valid_tgl <= ~valid_tgl; // level change marks a new sample.
        end
    end

    // ========================================
    // host clock side
    // ========================================

    logic valid_sync; // toggle level after the synchronizer.
    logic valid_prev; // last seen level, for edge detection.
    logic valid_edge;

    synchronizer #(
        .stages(`OPL3_SYNC_STAGES)
    ) u_valid_sync (
        .clk(clk_host),
        .rst(rst_host),
        .d  (valid_tgl),
        .q  (valid_sync)
    );

    assign valid_edge = valid_sync ^ valid_prev; // either edge is a new frame.

    always_ff @(posedge clk_host) begin
        if (rst_host) begin
            valid_prev  <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            valid_prev  <= valid_sync;
            frame_valid <= valid_edge; // one host cycle wide.
        end
    end

    // sums have been steady for several clk cycles by now.
    always_ff @(posedge clk_host) begin
        if (valid_edge) begin
            frame <= sum_frame;
        end
    end

    // back to back pulses would race the toggle through the crossing.
    a_valid_pulse: assert property (
        @(posedge clk) disable iff (rst) channel_valid |=> !channel_valid
    ) else $error("channel_valid high on two consecutive cycles.");

endmodule

// File: source/sample_credit_tx.sv
/*
 * Credit-based frame transmitter.
 * buffers stereo frames in a small circular FIFO and sends
 * them in order while the consumer holds credit. a push into
 * a full FIFO is dropped and sets a sticky overrun flag.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module sample_credit_tx
    import opl3_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  stereo_frame_t frame,
    input  logic          frame_valid,
    output stereo_frame_t out_frame,
    output logic          out_valid,
    input  logic          credit_return,
    output logic          overrun
);

    localparam int DEPTH    = `OPL3_FIFO_DEPTH;
    localparam int CREDITS  = `OPL3_CREDITS;
    localparam int PTR_W    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W    = $clog2(DEPTH + 1);
    localparam int CREDIT_W = $clog2(CREDITS + 1);

    // ========================================
    // frame storage
    // ========================================

    stereo_frame_t      mem [DEPTH]; // payload storage.
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count; // frames currently held.
    logic [CREDIT_W-1:0] credit_cnt; // beats the consumer can still take.

    logic full;
    logic push; // accepted frame.
    logic send; // one beat toward the consumer.

    assign full = (count == CNT_W'(DEPTH));
    assign push = frame_valid && !full;
    assign send = (credit_cnt != '0) && (count != '0);

    // head of the FIFO is always on the output.
    assign out_valid = send;
    assign out_frame = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= frame;
        end
    end

    // ========================================
    // pointers and fill level
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap.
            end
            if (send) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and send in one cycle leave the level alone.
            count <= count + CNT_W'(push) - CNT_W'(send);
        end
    end

    // ========================================
    // credits and overrun
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            credit_cnt <= CREDIT_W'(CREDITS); // full grant after reset.
            overrun    <= 1'b0;
        end else begin
            credit_cnt <= credit_cnt - CREDIT_W'(send) + CREDIT_W'(credit_return);
            if (frame_valid && full) begin
                overrun <= 1'b1; // sticky until reset.
            end
        end
    end

    // the consumer can only return what it was given.
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst) credit_cnt <= CREDIT_W'(CREDITS)
    ) else $error("credit count above the initial grant.");

    // spending the last credit with none coming back stops the next beat.
    a_credit_used: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && (credit_cnt == CREDIT_W'(1)) && !credit_return |=> !out_valid
    ) else $error("out_valid after the last credit was spent.");

endmodule

// File: source/opl3_output_stage.sv
/*
 * OPL3 digital output stage.
 * mixes the four operator channels into a stereo frame, moves
 * it into the host clock, and offers it to a consumer under
 * credit flow control.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module opl3_output_stage
    import opl3_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          clk_host,
    input  channel_set_t  channels,
    input  logic          channel_valid,
    output stereo_frame_t out_frame,
    output logic          out_valid,
    input  logic          credit_return,
    output logic          overrun
);

    logic          rst_host; // rst as seen in the host clock.
    stereo_frame_t frame; // host side frame from the adder.
    logic          frame_valid;

    // reset crosses like any other slow level; never self cleared.
    synchronizer #(
        .stages(`OPL3_SYNC_STAGES)
    ) u_rst_sync (
        .clk(clk_host),
        .rst(1'b0),
        .d  (rst),
        .q  (rst_host)
    );

    channel_adder u_channel_adder (
        .clk          (clk),
        .rst          (rst),
        .clk_host     (clk_host),
        .rst_host     (rst_host),
        .channels     (channels),
        .channel_valid(channel_valid),
        .frame        (frame),
        .frame_valid  (frame_valid)
    );

    sample_credit_tx u_sample_credit_tx (
        .clk          (clk_host), // transmitter lives in the host domain.
        .rst          (rst_host),
        .frame        (frame),
        .frame_valid  (frame_valid),
        .out_frame    (out_frame),
        .out_valid    (out_valid),
        .credit_return(credit_return),
        .overrun      (overrun)
    );

endmodule

// File: verif/output_checker.sv
/*
 * Output checker.
 * watches the consumer side of the output stage, compares each
 * sent frame with the next expected one in order, and keeps its
 * own count of the credits the consumer holds.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module output_checker
    import opl3_pkg::*;
(
    input  logic          clk_host,
    input  logic          rst,
    input  stereo_frame_t out_frame,
    input  logic          out_valid,
    input  logic          credit_return,
    output int            error_count,
    output int            beat_count,
    output int            pending
);

    stereo_frame_t expected_q[$]; // frames the stimulus has announced.
    int            credits; // beats the DUT may still send.

    initial begin
        error_count = 0;
        beat_count  = 0;
        pending     = 0;
        credits     = `OPL3_CREDITS;
    end

    // called by the stimulus before each channel_valid it expects out.
    task automatic expect_frame(input stereo_frame_t f);
        expected_q.push_back(f);
        pending = expected_q.size();
    endtask

    // ========================================
    // beat compare and credit tracking
    // ========================================

    // sampled mid-cycle where every output is settled.
    always @(negedge clk_host) begin : watch
        stereo_frame_t want;
        if (rst === 1'b1) begin
            expected_q.delete(); // a reset flushes the FIFO too.
            pending = 0;
            credits = `OPL3_CREDITS;
        end else if (out_valid !== 1'b0 && out_valid !== 1'b1) begin
            $display("at %0t ns out_valid is unknown outside reset.", $time);
            error_count++;
        end else begin
            if (out_valid) begin
                beat_count++;
                if (credits <= 0) begin
                    $display("at %0t ns out_valid was sent with no credit left.", $time);
                    error_count++;
                end
                if (expected_q.size() == 0) begin
                    // a duplicate or a dropped frame leaking out.
                    $display("at %0t ns out_valid came with no frame expected.", $time);
                    error_count++;
                end else begin
                    want = expected_q.pop_front();
                    if (out_frame.l !== want.l) begin
                        $display("FAILED at %0t ns: out_frame.l expected %h, got %h",
                                 $time, want.l, out_frame.l);
                        error_count++;
                    end
                    if (out_frame.r !== want.r) begin
                        $display("FAILED at %0t ns: out_frame.r expected %h, got %h",
                                 $time, want.r, out_frame.r);
                        error_count++;
                    end
                end
                pending = expected_q.size();
            end
            // both take effect on the coming host edge.
            credits = credits - int'(out_valid === 1'b1) + int'(credit_return === 1'b1);
        end
    end

endmodule

// File: verif/tb_opl3_output_stage.sv
/*
 * Testbench for the OPL3 output stage.
 * plays the operator core in clk and the credit consumer in
 * clk_host, and walks reset, mixing, ordering, credit limit,
 * overrun and recovery.
 */
`timescale 1ns/1ps
`include "opl3_defs.svh"

module tb_opl3_output_stage
    import opl3_pkg::*;
();

    localparam int credits    = `OPL3_CREDITS;
    localparam int depth      = `OPL3_FIFO_DEPTH;
    localparam int gap_cycles = 40; // clk cycles between channel_valid pulses.
    localparam int frames_total = 1 + 50 + 20 + (credits + 2) + (credits + depth + 2) + 50;
    localparam int cycle_limit  = frames_total * gap_cycles * 2 + 200;
    localparam int unlimited    = 1000000; // budget for immediate credit return.

    logic          clk;
    logic          clk_host;
    logic          rst;
    channel_set_t  channels;
    logic          channel_valid;
    stereo_frame_t out_frame;
    logic          out_valid;
    logic          credit_return;
    logic          overrun;

    int check_errors; // from the checker.
    int beat_count;
    int pending; // expected frames not yet seen.
    int tb_errors;
    int tests_run;
    int tests_failed;
    int errors_at_start;
    int owed; // beats taken, credit not yet returned.
    int return_budget; // credits the consumer may still give back.
    int cycle_count;

    // ========================================
    // clocks, DUT and checker
    // ========================================

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns.
    end

    initial begin
        clk_host = 1'b0;
        #3; // offset phase against clk.
        forever #5 clk_host = ~clk_host; // 10 ns.
    end

    opl3_output_stage u_opl3_output_stage (
        .clk          (clk),
        .rst          (rst),
        .clk_host     (clk_host),
        .channels     (channels),
        .channel_valid(channel_valid),
        .out_frame    (out_frame),
        .out_valid    (out_valid),
        .credit_return(credit_return),
        .overrun      (overrun)
    );

    output_checker u_output_checker (
        .clk_host     (clk_host),
        .rst          (rst),
        .out_frame    (out_frame),
        .out_valid    (out_valid),
        .credit_return(credit_return),
        .error_count  (check_errors),
        .beat_count   (beat_count),
        .pending      (pending)
    );

    // consumer: counts accepted beats mid-cycle.
    always @(negedge clk_host) begin
        if (rst) owed = 0;
        else if (out_valid === 1'b1) owed++;
    end

    // gives one credit back per host cycle while the budget allows.
    always @(posedge clk_host) begin
        #1;
        if (!rst && owed > 0 && return_budget > 0) begin
            credit_return = 1'b1;
            owed--;
            return_budget--;
        end else begin
            credit_return = 1'b0;
        end
    end

    // ========================================
    // reference and helpers
    // ========================================

    // left is a + c, right is b + d, both scaled up by 2^shift.
    function automatic stereo_frame_t mix_frame(input channel_set_t cs);
        stereo_frame_t f;
        int            l_sum;
        int            r_sum;
        l_sum = (int'(cs.a) + int'(cs.c)) * (1 << `OPL3_DAC_LEFT_SHIFT);
        r_sum = (int'(cs.b) + int'(cs.d)) * (1 << `OPL3_DAC_LEFT_SHIFT);
        f.l = l_sum[`OPL3_DAC_WIDTH-1:0];
        f.r = r_sum[`OPL3_DAC_WIDTH-1:0];
        return f;
    endfunction

    function automatic channel_set_t random_channels();
        return channel_set_t'({$urandom, $urandom});
    endfunction

    function automatic int total_errors();
        return tb_errors + check_errors;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            tb_errors++;
        end
    endtask

    task automatic start_test();
        errors_at_start = total_errors();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_errors() > errors_at_start) begin
            tests_failed++;
            $display("test %0d %s: failed", tests_run, name);
        end else begin
            $display("test %0d %s: passed", tests_run, name);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk_host); // host reset trails through its synchronizer.
    endtask

    // one channel_valid pulse, then the rest of the sample period.
    task automatic send_channels(input channel_set_t cs, input bit expect_out);
        if (expect_out) u_output_checker.expect_frame(mix_frame(cs));
        @(posedge clk);
        #1;
        channels      = cs;
        channel_valid = 1'b1;
        @(posedge clk);
        #1;
        channel_valid = 1'b0;
        repeat (gap_cycles - 2) @(posedge clk);
    endtask

    task automatic wait_drained();
        while (pending != 0 || owed != 0) @(posedge clk_host);
        repeat (2) @(posedge clk_host);
    endtask

    // extremes first for sign extension and shift, then random sets.
    task automatic run_mix_test(input int n);
        channel_set_t cs;
        return_budget = unlimited;
        for (int i = 0; i < n; i++) begin
            cs = random_channels();
            if (i == 0) cs = '{a: 16'h7fff, b: 16'h8000, c: 16'h7fff, d: 16'h8000};
            if (i == 1) cs = '{a: 16'h8000, b: 16'h7fff, c: 16'h8000, d: 16'h7fff};
            if (i == 2) cs = '{a: 16'hffff, b: 16'h8000, c: 16'h0001, d: 16'h7fff};
            send_channels(cs, 1'b1);
        end
        wait_drained();
        check_value("overrun", 0, overrun);
    endtask

    // ========================================
    // timeout
    // ========================================

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d clk cycles, the tests did not finish.", cycle_count);
        $display("=== FAIL ===");
        $finish;
    end

    // ========================================
    // test sequence
    // ========================================

    initial begin
        int beats;
        void'($urandom(32'h38c1));
        rst           = 1'b1;
        channels      = '0;
        channel_valid = 1'b0;
        credit_return = 1'b0;
        tb_errors     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        owed          = 0;
        return_budget = 0;
        apply_reset();

        start_test(); // reset state, nothing may leave before a sample.
        @(negedge clk_host);
        check_value("out_valid", 0, out_valid);
        check_value("overrun", 0, overrun);
        beats = beat_count;
        repeat (gap_cycles) @(posedge clk);
        check_value("out_valid beats", beats, beat_count);
        finish_test("reset state");

        start_test();
        run_mix_test(50);
        finish_test("mixing rule");

        start_test(); // one beat per sample across the crossing.
        beats = beat_count;
        return_budget = unlimited;
        for (int i = 0; i < 20; i++) send_channels(random_channels(), 1'b1);
        wait_drained();
        check_value("out_valid beats", beats + 20, beat_count);
        finish_test("order and crossing");

        start_test(); // credits held back, then released one by one.
        return_budget = 0;
        beats = beat_count;
        for (int i = 0; i < credits + 2; i++) send_channels(random_channels(), 1'b1);
        repeat (20) @(posedge clk_host);
        check_value("out_valid beats", beats + credits, beat_count);
        for (int k = 1; k <= 2; k++) begin
            return_budget = 1;
            repeat (20) @(posedge clk_host);
            check_value("out_valid beats", beats + credits + k, beat_count);
        end
        return_budget = unlimited;
        wait_drained();
        finish_test("credit limit");

        start_test(); // last two frames find the FIFO full.
        return_budget = 0;
        beats = beat_count;
        for (int i = 0; i < credits + depth + 2; i++) begin
            send_channels(random_channels(), i < credits + depth);
        end
        return_budget = unlimited;
        wait_drained();
        repeat (40) @(posedge clk_host);
        check_value("out_valid beats", beats + credits + depth, beat_count);
        check_value("overrun", 1, overrun);
        finish_test("overrun");

        start_test();
        apply_reset();
        @(negedge clk_host);
        check_value("overrun", 0, overrun);
        check_value("out_valid", 0, out_valid);
        run_mix_test(50);
        finish_test("recovery");

        $display("tests run %0d, failed %0d, check errors %0d",
                 tests_run, tests_failed, total_errors());
        if (tests_failed == 0 && total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+source
source/opl3_pkg.sv
source/synchronizer.sv
source/channel_adder.sv
source/sample_credit_tx.sv
source/opl3_output_stage.sv
verif/output_checker.sv
verif/tb_opl3_output_stage.sv

// File: Bender.yml
package:
  name: opl3_output_stage

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/opl3_pkg.sv
      - source/synchronizer.sv
      - source/channel_adder.sv
      - source/sample_credit_tx.sv
      - source/opl3_output_stage.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/output_checker.sv
      - verif/tb_opl3_output_stage.sv
